// File: design/cache_pkg.sv
// shared bus structs, word and way types and fixed constants for the l2 cache design
`default_nettype none

package cache_pkg;

    ////////////////////
    // basic types
    ////////////////////

    typedef logic [31:0] word_t;    // one bus word
    typedef logic [31:0] addr_t;    // byte address
    typedef logic [3:0]  byte_en_t; // one bit per byte lane

    localparam int BYTE_OFFSET_BITS = 2; // byte offset inside a word
    localparam int WAYS             = 4; // associativity, fixed

    typedef logic [1:0] way_idx_t; // way number within a set

    // replacement order of one set, front entry is evicted first
    typedef struct packed {
        way_idx_t       v;  // victim
        way_idx_t       nv; // next victim
        way_idx_t [1:0] o;  // o[1] is the most recently used
    } lru_list_t;

    ////////////////////
    // bus structs
    ////////////////////

    // processor side, held until busy drops
    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en; // only honoured on pass-through writes
    } proc_req_t;

    typedef struct packed {
        logic  busy;  // low in the completing cycle
        word_t rdata; // valid with busy low on a read
    } proc_rsp_t;

    // memory side, same handshake
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;  // memory back-pressure
        word_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: design/tag_store.sv
// frame array of the cache with valid, dirty, tag and data, and the hit lookup for one set
`timescale 1ns/1ps
`default_nettype none

module tag_store #(
    parameter int CACHE_SIZE = 4096, // bits of data storage
    parameter int BLOCK_SIZE = 4     // words per frame
) (
    input  wire logic                       CLK,
    input  wire logic                       nRST,
    input  wire cache_pkg::addr_t           addr,
    input  wire cache_pkg::way_idx_t        fill_way,
    input  wire logic [WORD_SEL_BITS-1:0]   word_sel,
    input  wire cache_pkg::word_t           fill_word,
    input  wire cache_pkg::word_t           hit_wdata,
    input  wire logic                       write_hit,
    input  wire logic                       write_fill,
    input  wire logic                       set_valid,
    input  wire logic                       clear_dirty,
    output cache_pkg::word_t                victim_word,
    output logic                            hit,
    output cache_pkg::way_idx_t             hit_way,
    output cache_pkg::word_t                hit_word,
    output logic                            victim_dirty,
    output logic [TAG_BITS-1:0]             victim_tag
);

    localparam int N_SETS        = CACHE_SIZE / (BLOCK_SIZE * 32) / cache_pkg::WAYS;
    localparam int BLOCK_BITS    = $clog2(BLOCK_SIZE);
    localparam int SET_BITS      = $clog2(N_SETS);
    localparam int SET_SHIFT     = cache_pkg::BYTE_OFFSET_BITS + BLOCK_BITS;
    localparam int TAG_SHIFT     = SET_SHIFT + SET_BITS;
    localparam int TAG_BITS      = 32 - TAG_SHIFT;
    localparam int SET_IDX_BITS  = (SET_BITS > 0) ? SET_BITS : 1;
    localparam int WORD_SEL_BITS = (BLOCK_BITS > 0) ? BLOCK_BITS : 1;

    // frame storage, only valid and dirty are cleared
    logic [cache_pkg::WAYS-1:0] valid_q [N_SETS];
    logic [cache_pkg::WAYS-1:0] dirty_q [N_SETS];
    logic [TAG_BITS-1:0]        tag_q   [N_SETS][cache_pkg::WAYS];
    cache_pkg::word_t           data_q  [N_SETS][cache_pkg::WAYS][BLOCK_SIZE];

    logic [SET_IDX_BITS-1:0]  set_idx;
    logic [WORD_SEL_BITS-1:0] addr_word; // word within the block
    logic [TAG_BITS-1:0]      addr_tag;

    assign set_idx   = SET_IDX_BITS'((addr >> SET_SHIFT) & (N_SETS - 1));
    assign addr_word = WORD_SEL_BITS'((addr >> cache_pkg::BYTE_OFFSET_BITS) & (BLOCK_SIZE - 1));
    assign addr_tag  = TAG_BITS'(addr >> TAG_SHIFT);

    ////////////////////
    // lookup
    ////////////////////

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (valid_q[set_idx][w] && (tag_q[set_idx][w] == addr_tag)) begin
                hit     = 1'b1;
                hit_way = cache_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit_word     = data_q[set_idx][hit_way][addr_word];
    assign victim_dirty = dirty_q[set_idx][fill_way];    // write-back needed
    assign victim_tag   = tag_q[set_idx][fill_way];      // block base of write-back
    assign victim_word  = data_q[set_idx][fill_way][word_sel];

    ////////////////////
    // updates
    ////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (write_hit) begin
                dirty_q[set_idx][hit_way] <= 1'b1;   // frame now differs from memory
            end
            if (set_valid) begin
                valid_q[set_idx][fill_way] <= 1'b1;
                dirty_q[set_idx][fill_way] <= 1'b0;  // fresh copy
            end else if (clear_dirty) begin
                dirty_q[set_idx][fill_way] <= 1'b0;  // write-back finished
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (write_hit) begin
            data_q[set_idx][hit_way][addr_word] <= hit_wdata;  // whole word stored
        end
        if (write_fill) begin
            data_q[set_idx][fill_way][word_sel] <= fill_word;
        end
        if (set_valid) begin
            tag_q[set_idx][fill_way] <= addr_tag;
        end
    end

endmodule

`default_nettype wire

// File: design/lru_order.sv
// per-set replacement order list, gives the victim way and moves a served way to the back
`timescale 1ns/1ps
`default_nettype none

module lru_order #(
    parameter int CACHE_SIZE = 4096, // bits of data storage
    parameter int BLOCK_SIZE = 4     // words per frame
) (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire cache_pkg::addr_t    set_addr,
    input  wire logic                touch,
    input  wire cache_pkg::way_idx_t touch_way,
    output cache_pkg::way_idx_t      victim
);

    localparam int N_SETS       = CACHE_SIZE / (BLOCK_SIZE * 32) / cache_pkg::WAYS;
    localparam int SET_BITS     = $clog2(N_SETS);
    localparam int SET_SHIFT    = cache_pkg::BYTE_OFFSET_BITS + $clog2(BLOCK_SIZE);
    localparam int SET_IDX_BITS = (SET_BITS > 0) ? SET_BITS : 1;

    cache_pkg::lru_list_t    order_q [N_SETS];
    cache_pkg::lru_list_t    cur;      // list of the addressed set
    cache_pkg::lru_list_t    nxt;
    logic [SET_IDX_BITS-1:0] set_idx;

    assign set_idx = SET_IDX_BITS'((set_addr >> SET_SHIFT) & (N_SETS - 1));
    assign cur     = order_q[set_idx];
    assign victim  = cur.v;            // front of the list

    // touched way goes to the back, the rest keep their order
    always_comb begin
        nxt = cur;
        if (touch_way == cur.v) begin
            nxt = '{v: cur.nv, nv: cur.o[0], o: {cur.v, cur.o[1]}};
        end else if (touch_way == cur.nv) begin
            nxt = '{v: cur.v, nv: cur.o[0], o: {cur.nv, cur.o[1]}};
        end else if (touch_way == cur.o[0]) begin
            nxt = '{v: cur.v, nv: cur.nv, o: {cur.o[0], cur.o[1]}};
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                order_q[s] <= '{v: 2'd0, nv: 2'd1, o: {2'd3, 2'd2}}; // 0,1,2,3
            end
        end else if (touch) begin
            order_q[set_idx] <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/cache_ctrl.sv
// cache FSM: serves hits, runs write-back and fetch on a miss, routes pass-through accesses
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int               CACHE_SIZE          = 4096,
    parameter int               BLOCK_SIZE          = 4,
    parameter cache_pkg::addr_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  wire logic                     CLK,
    input  wire logic                     nRST,
    input  wire cache_pkg::proc_req_t     proc_req,
    input  wire cache_pkg::mem_rsp_t      mem_rsp,
    input  wire logic                     hit,
    input  wire logic                     victim_dirty,
    input  wire cache_pkg::way_idx_t      hit_way,
    input  wire cache_pkg::way_idx_t      victim,
    input  wire cache_pkg::word_t         hit_word,
    input  wire logic [TAG_BITS-1:0]      victim_tag,
    input  wire cache_pkg::word_t         victim_word,
    output cache_pkg::proc_rsp_t          proc_rsp,
    output cache_pkg::mem_req_t           mem_req,
    output logic                          write_hit,
    output logic                          write_fill,
    output logic                          set_valid,
    output logic                          clear_dirty,
    output logic [WORD_SEL_BITS-1:0]      word_sel,
    output cache_pkg::way_idx_t           fill_way,
    output logic                          touch,
    output cache_pkg::way_idx_t           touch_way
);

    localparam int N_SETS        = CACHE_SIZE / (BLOCK_SIZE * 32) / cache_pkg::WAYS;
    localparam int BLOCK_BITS    = $clog2(BLOCK_SIZE);
    localparam int SET_SHIFT     = cache_pkg::BYTE_OFFSET_BITS + BLOCK_BITS;
    localparam int TAG_SHIFT     = SET_SHIFT + $clog2(N_SETS);
    localparam int TAG_BITS      = 32 - TAG_SHIFT;
    localparam int WORD_SEL_BITS = (BLOCK_BITS > 0) ? BLOCK_BITS : 1;
    localparam int CNT_BITS      = BLOCK_BITS + 1;               // counts up to BLOCK_SIZE
    localparam cache_pkg::addr_t BLOCK_MASK = cache_pkg::addr_t'(BLOCK_SIZE * 4 - 1);
    localparam cache_pkg::addr_t SET_MASK   = cache_pkg::addr_t'(N_SETS - 1) << SET_SHIFT;

    typedef enum logic [1:0] {IDLE, WB, FETCH} state_t;

    state_t                 state;
    logic [CNT_BITS-1:0]    word_cnt;   // memory completions so far
    cache_pkg::addr_t       mem_addr;   // next memory word address
    cache_pkg::way_idx_t    victim_q;   // frame being replaced

    logic             req_valid;
    logic             pass_thru;
    logic             miss;
    logic             last_word;
    logic             fill_done;
    cache_pkg::addr_t req_base;
    cache_pkg::addr_t victim_base;
    cache_pkg::word_t pass_wdata;

    assign req_valid   = proc_req.ren | proc_req.wen;
    assign pass_thru   = proc_req.addr >= NONCACHE_START_ADDR;
    assign miss        = (state == IDLE) & req_valid & ~pass_thru & ~hit;
    assign last_word   = word_cnt == CNT_BITS'(BLOCK_SIZE - 1);
    assign fill_done   = word_cnt == CNT_BITS'(BLOCK_SIZE);
    assign req_base    = proc_req.addr & ~BLOCK_MASK;
    assign victim_base = (cache_pkg::addr_t'(victim_tag) << TAG_SHIFT) | (proc_req.addr & SET_MASK);

    assign word_sel  = WORD_SEL_BITS'(word_cnt);
    assign fill_way  = (state == IDLE) ? victim : victim_q; // victim held for the whole miss
    assign touch_way = hit_way;

    // pass-through lane masking, unlisted enables send the full word
    always_comb begin
        case (proc_req.byte_en)
            4'b0001: pass_wdata = {24'd0, proc_req.wdata[7:0]};
            4'b0010: pass_wdata = {16'd0, proc_req.wdata[15:8], 8'd0};
            4'b0100: pass_wdata = {8'd0, proc_req.wdata[23:16], 16'd0};
            4'b1000: pass_wdata = {proc_req.wdata[31:24], 24'd0};
            4'b0011: pass_wdata = {16'd0, proc_req.wdata[15:0]};
            4'b1100: pass_wdata = {proc_req.wdata[31:16], 16'd0};
            default: pass_wdata = proc_req.wdata;
        endcase
    end

    ////////////////////
    // state and counters
    ////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
            mem_addr <= '0;
            victim_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        victim_q <= victim;
                        word_cnt <= '0;
                        if (victim_dirty) begin
                            state    <= WB;          // old block goes out first
                            mem_addr <= victim_base;
                        end else begin
                            state    <= FETCH;
                            mem_addr <= req_base;
                        end
                    end
                end
                WB: begin
                    if (!mem_rsp.busy) begin
                        if (last_word) begin
                            state    <= FETCH;       // straight into the refill
                            word_cnt <= '0;
                            mem_addr <= req_base;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            mem_addr <= mem_addr + cache_pkg::addr_t'(4);
                        end
                    end
                end
                FETCH: begin
                    if (fill_done) begin
                        state    <= IDLE;            // request hits next cycle
                        word_cnt <= '0;
                    end else if (!mem_rsp.busy) begin
                        word_cnt <= word_cnt + 1'b1;
                        mem_addr <= mem_addr + cache_pkg::addr_t'(4);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // bus outputs and store commands
    ////////////////////

    always_comb begin
        proc_rsp.busy  = 1'b1;
        proc_rsp.rdata = hit_word;
        mem_req.ren    = 1'b0;
        mem_req.wen    = 1'b0;
        mem_req.addr   = mem_addr;
        mem_req.wdata  = victim_word;
        write_hit      = 1'b0;
        write_fill     = 1'b0;
        set_valid      = 1'b0;
        clear_dirty    = 1'b0;
        touch          = 1'b0;
        case (state)
            IDLE: begin
                if (req_valid && pass_thru) begin
                    mem_req.ren    = proc_req.ren;
                    mem_req.wen    = proc_req.wen;
                    mem_req.addr   = proc_req.addr;
                    mem_req.wdata  = pass_wdata;
                    proc_rsp.busy  = mem_rsp.busy;   // memory sets the pace
                    proc_rsp.rdata = mem_rsp.rdata;
                end else if (req_valid && hit) begin
                    proc_rsp.busy = 1'b0;            // same-cycle hit
                    write_hit     = proc_req.wen;
                    touch         = 1'b1;
                end
            end
            WB: begin
                mem_req.wen = 1'b1;
                clear_dirty = ~mem_rsp.busy & last_word;
            end
            FETCH: begin
                mem_req.ren = ~fill_done;
                write_fill  = ~fill_done & ~mem_rsp.busy;
                set_valid   = fill_done;             // tag written with valid
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/l2_cache.sv
// top level of the l2 cache, connects the frame store, the order list and the controller
`timescale 1ns/1ps
`default_nettype none

module l2_cache #(
    parameter int               CACHE_SIZE          = 4096,          // in bits
    parameter int               BLOCK_SIZE          = 4,             // words, power of two up to 4
    parameter cache_pkg::addr_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  wire logic                 CLK,
    input  wire logic                 nRST,
    input  wire cache_pkg::proc_req_t proc_req,
    output cache_pkg::proc_rsp_t      proc_rsp,
    output cache_pkg::mem_req_t       mem_req,
    input  wire cache_pkg::mem_rsp_t  mem_rsp
);

    localparam int N_SETS        = CACHE_SIZE / (BLOCK_SIZE * 32) / cache_pkg::WAYS;
    localparam int BLOCK_BITS    = $clog2(BLOCK_SIZE);
    localparam int TAG_BITS      = 32 - cache_pkg::BYTE_OFFSET_BITS - BLOCK_BITS - $clog2(N_SETS);
    localparam int WORD_SEL_BITS = (BLOCK_BITS > 0) ? BLOCK_BITS : 1;

    logic                     hit;
    logic                     victim_dirty;
    logic                     write_hit;
    logic                     write_fill;
    logic                     set_valid;
    logic                     clear_dirty;
    logic                     touch;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic [TAG_BITS-1:0]      victim_tag;
    cache_pkg::way_idx_t      hit_way;
    cache_pkg::way_idx_t      touch_way;
    cache_pkg::way_idx_t      victim;
    cache_pkg::way_idx_t      fill_way;
    cache_pkg::word_t         hit_word;
    cache_pkg::word_t         victim_word;

    tag_store #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) store_i (
        .CLK(CLK), .nRST(nRST),
        .addr(proc_req.addr), .fill_way(fill_way), .word_sel(word_sel),
        .fill_word(mem_rsp.rdata), .hit_wdata(proc_req.wdata),     // refill and hit data
        .write_hit(write_hit), .write_fill(write_fill),
        .set_valid(set_valid), .clear_dirty(clear_dirty),
        .victim_word(victim_word), .hit(hit), .hit_way(hit_way), .hit_word(hit_word),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    lru_order #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE)) order_i (
        .CLK(CLK), .nRST(nRST),
        .set_addr(proc_req.addr), .touch(touch), .touch_way(touch_way),
        .victim(victim)
    );

    cache_ctrl #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) ctrl_i (
        .CLK(CLK), .nRST(nRST),
        .proc_req(proc_req), .mem_rsp(mem_rsp),
        .hit(hit), .victim_dirty(victim_dirty), .hit_way(hit_way), .victim(victim),
        .hit_word(hit_word), .victim_tag(victim_tag), .victim_word(victim_word),
        .proc_rsp(proc_rsp), .mem_req(mem_req),
        .write_hit(write_hit), .write_fill(write_fill),
        .set_valid(set_valid), .clear_dirty(clear_dirty),
        .word_sel(word_sel), .fill_way(fill_way),
        .touch(touch), .touch_way(touch_way)
    );

endmodule

`default_nettype wire

// File: bench/mem_model.sv
// memory responder for the l2 cache testbench, random busy latency, word storage and a write log
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t      mem_rsp = '{busy: 1'b1, rdata: '0}
);

    cache_pkg::word_t store [cache_pkg::addr_t]; // only written words live here
    cache_pkg::addr_t log_addr [$];              // every completed write
    cache_pkg::word_t log_data [$];
    logic [1:0]       wait_cnt = '0;             // busy cycles left before completion
    logic             active;

    assign active = mem_req.ren | mem_req.wen;

    // power-on contents built from every address bit
    function automatic cache_pkg::word_t fill_word(input cache_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic cache_pkg::word_t peek(input cache_pkg::addr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return fill_word(a);
    endfunction

    always @(posedge CLK) begin
        if (active && !mem_rsp.busy) begin      // completion at this edge
            if (mem_req.wen) begin
                store[mem_req.addr] = mem_req.wdata;
                log_addr.push_back(mem_req.addr);
                log_data.push_back(mem_req.wdata);
            end
            wait_cnt <= 2'($urandom);           // 0 to 3 busy cycles next time
        end else if (active && wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    // response changes on the falling edge and is stable at the rising one
    always @(negedge CLK) begin
        mem_rsp.busy  <= !(nRST && active && wait_cnt == 2'd0);
        mem_rsp.rdata <= peek(mem_req.addr);
    end

endmodule

`default_nettype wire

// File: bench/l2_cache_tb.sv
// testbench for the l2 cache, drives directed and random requests and checks data and write-backs
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;

    localparam int               CACHE_SIZE = 4096;
    localparam int               BS         = 4;     // block size in words
    localparam cache_pkg::addr_t NONCACHE   = 32'h8000_0000;
    localparam int               N_SETS     = CACHE_SIZE / (BS * 32) / cache_pkg::WAYS;
    localparam int               SET_SHIFT  = 4;     // byte offset plus word in block
    localparam int               TAG_SHIFT  = 7;
    localparam int               N_REQ      = 70;
    localparam int               LIMIT      = 8 + N_REQ * (2 * BS * 4 + 8);

    logic                 CLK = 1'b0;
    logic                 nRST;
    cache_pkg::proc_req_t proc_req;
    cache_pkg::proc_rsp_t proc_rsp;
    cache_pkg::mem_req_t  mem_req;
    cache_pkg::mem_rsp_t  mem_rsp;

    int               errors = 0;
    int               cycles = 0;
    cache_pkg::word_t exp_rdata;
    cache_pkg::word_t shadow [cache_pkg::addr_t];    // coherent memory image
    cache_pkg::addr_t ref_tag   [N_SETS][4];
    bit               ref_valid [N_SETS][4];
    bit               ref_dirty [N_SETS][4];
    int               ref_order [N_SETS][4];         // entry 0 is the victim

    l2_cache #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BS), .NONCACHE_START_ADDR(NONCACHE)) dut_i (
        .CLK(CLK), .nRST(nRST), .proc_req(proc_req), .proc_rsp(proc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    mem_model mem_i (.CLK(CLK), .nRST(nRST), .mem_req(mem_req), .mem_rsp(mem_rsp));

    always #10 CLK = ~CLK;

    ////////////////////
    // reference model
    ////////////////////

    function automatic cache_pkg::word_t initial_word(input cache_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;  // memory power-on image
    endfunction

    function automatic cache_pkg::word_t expected_read(input cache_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return initial_word(a);
    endfunction

    // listed enables keep their lanes, anything else goes out whole
    function automatic cache_pkg::word_t lane_mask(input cache_pkg::word_t wd,
                                                   input cache_pkg::byte_en_t be);
        cache_pkg::word_t res;
        res = wd;
        if (be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100}) begin
            for (int i = 0; i < 4; i++) begin
                if (!be[i]) begin
                    res[i*8 +: 8] = 8'h00;
                end
            end
        end
        return res;
    endfunction

    // picks hit or victim and the write-back base and updates the order list
    function automatic logic predict_victim(input cache_pkg::addr_t a, input logic is_wr,
                                            output logic was_hit,
                                            output cache_pkg::addr_t wb_base);
        int               s;
        int               way;
        int               pos;
        logic             wb;
        cache_pkg::addr_t t;
        s       = int'((a >> SET_SHIFT) % N_SETS);
        t       = a >> TAG_SHIFT;
        way     = -1;
        wb      = 1'b0;
        wb_base = '0;
        pos     = 0;
        for (int w = 0; w < 4; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) begin
                way = w;
            end
        end
        was_hit = (way >= 0);
        if (way < 0) begin                           // on a miss the front of the list goes
            way     = ref_order[s][0];
            wb      = ref_valid[s][way] && ref_dirty[s][way];
            wb_base = (ref_tag[s][way] << TAG_SHIFT) | cache_pkg::addr_t'(s << SET_SHIFT);
            ref_valid[s][way] = 1'b1;
            ref_dirty[s][way] = 1'b0;
            ref_tag[s][way]   = t;
        end
        if (is_wr) begin
            ref_dirty[s][way] = 1'b1;
        end
        for (int i = 0; i < 4; i++) begin
            if (ref_order[s][i] == way) begin
                pos = i;
            end
        end
        for (int i = pos; i < 3; i++) begin
            ref_order[s][i] = ref_order[s][i+1];
        end
        ref_order[s][3] = way;                       // served way to the back
        return wb;
    endfunction

    ////////////////////
    // checks
    ////////////////////

    task automatic check_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // read data compared in the completing cycle
    always @(posedge CLK) begin
        if (nRST && proc_req.ren && !proc_rsp.busy) begin
            check_word("proc_rsp.rdata", proc_rsp.rdata, exp_rdata);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: requests not finished after %0d cycles", cycles);
            $display("errors: %0d", errors);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // runs one request and compares the new memory writes with the prediction
    task automatic access(input logic wr, input cache_pkg::addr_t a, input cache_pkg::word_t wd,
                          input cache_pkg::byte_en_t be);
        cache_pkg::addr_t wb_base;
        cache_pkg::addr_t exp_addr [$];
        cache_pkg::word_t exp_data [$];
        int               n_before;
        int               n_wait;
        logic             exp_hit;
        n_before = mem_i.log_addr.size();
        exp_hit  = 1'b0;
        if (a >= NONCACHE) begin
            if (wr) begin
                exp_addr.push_back(a);
                exp_data.push_back(lane_mask(wd, be));
                shadow[a] = lane_mask(wd, be);
            end
        end else begin
            if (predict_victim(a, wr, exp_hit, wb_base)) begin
                for (int i = 0; i < BS; i++) begin
                    exp_addr.push_back(wb_base + cache_pkg::addr_t'(4 * i));
                    exp_data.push_back(expected_read(wb_base + cache_pkg::addr_t'(4 * i)));
                end
            end
            if (wr) begin
                shadow[a] = wd;                      // whole word on cached writes
            end
        end
        exp_rdata = expected_read(a);
        n_wait    = 0;
        @(posedge CLK);
        proc_req <= '{ren: !wr, wen: wr, addr: a, wdata: wd, byte_en: be};
        do begin
            @(posedge CLK);
            n_wait++;
        end while (proc_rsp.busy);
        proc_req <= '0;
        if (a < NONCACHE && (n_wait == 1) != exp_hit) begin  // a hit completes at once
            errors++;
            $display("cached access to %h at %0t took %0d cycles where the reference expects a %s",
                     a, $time, n_wait, exp_hit ? "hit" : "miss");
        end
        @(negedge CLK);                              // log settled
        if (mem_i.log_addr.size() - n_before != exp_addr.size()) begin
            errors++;
            $display("wrong number of memory writes at %0t for address %h: %0d instead of %0d",
                     $time, a, mem_i.log_addr.size() - n_before, exp_addr.size());
        end else begin
            foreach (exp_addr[i]) begin
                check_addr("mem_req.addr", mem_i.log_addr[n_before + i], exp_addr[i]);
                check_word("mem_req.wdata", mem_i.log_data[n_before + i], exp_data[i]);
            end
        end
    endtask

    initial begin
        cache_pkg::addr_t a;
        cache_pkg::byte_en_t ens [7];
        void'($urandom(32'h6402014a));
        ens      = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
        nRST     = 1'b0;
        proc_req = '0;
        for (int s = 0; s < N_SETS; s++) begin
            for (int w = 0; w < 4; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_order[s][w] = w;                 // reset order 0,1,2,3
            end
        end
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;

        access(1'b0, 32'h0000_0104, '0, 4'hf);       // read miss then repeat
        access(1'b0, 32'h0000_0104, '0, 4'hf);
        access(1'b0, 32'h0000_0208, '0, 4'hf);
        access(1'b1, 32'h0000_0104, 32'h1111_2222, 4'hf); // write hit with no memory write yet
        access(1'b0, 32'h0000_0104, '0, 4'hf);
        for (int t = 1; t <= 5; t++) begin           // five tags in set 0
            access(1'b1, cache_pkg::addr_t'(t << TAG_SHIFT) | 32'h8, $urandom, 4'hf);
        end
        for (int t = 1; t <= 5; t++) begin
            access(1'b0, cache_pkg::addr_t'(t << TAG_SHIFT) | 32'h8, '0, 4'hf);
        end
        foreach (ens[i]) begin                       // pass-through lane masking
            access(1'b1, NONCACHE + cache_pkg::addr_t'(4 * i), 32'hcafe_f00d, ens[i]);
        end
        access(1'b0, 32'h0000_0208, '0, 4'hf);
        foreach (ens[i]) begin
            access(1'b0, NONCACHE + cache_pkg::addr_t'(4 * i), '0, 4'hf);
        end
        for (int n = 0; n < 40; n++) begin           // mixed random traffic
            if ($urandom % 8 == 0) begin
                a = NONCACHE | (cache_pkg::addr_t'($urandom) & 32'h3c);
            end else begin
                a = cache_pkg::addr_t'($urandom) & 32'h3fc;
            end
            access(1'($urandom), a, $urandom, 4'($urandom));
        end

        repeat (2) @(posedge CLK);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
design/cache_pkg.sv
design/tag_store.sv
design/lru_order.sv
design/cache_ctrl.sv
design/l2_cache.sv
bench/mem_model.sv
bench/l2_cache_tb.sv

// File: run.sh
#!/bin/bash
# builds the l2 cache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module l2_cache_tb -o l2_cache_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/l2_cache_sim)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
